// ==== logic/axi_pkg.sv ====
package axi_pkg;

    // Bus widths
    localparam int DATA_BITS  = 32;
    localparam int STRB_BITS  = DATA_BITS / 8;
    localparam int LEN_BITS   = 4;
    localparam int SIZE_BITS  = 3;
    localparam int BURST_BITS = 2;
    localparam int ID_BITS    = 4;

    // Burst length is beats minus one
    localparam logic [LEN_BITS-1:0] LEN_ONE  = LEN_BITS'(0);
    localparam logic [LEN_BITS-1:0] LEN_FOUR = LEN_BITS'(3);

    localparam logic [BURST_BITS-1:0] BURST_FIXED = 2'b00;
    localparam logic [BURST_BITS-1:0] BURST_INCR  = 2'b01;

    // Four bytes per beat
    localparam logic [SIZE_BITS-1:0] SIZE_WORD = 3'b010;

    // Slave memory depth in words
    localparam int MEM_WORDS = 256;

    // Cache write type
    typedef enum logic [1:0] {
        WT_BYTE = 2'b00,
        WT_HALF = 2'b01,
        WT_WORD = 2'b10
    } wtype_e;

    // Master FSM states
    typedef enum logic [2:0] {
        ST_IDLE = 3'd0,
        ST_AR   = 3'd1,
        ST_R    = 3'd2,
        ST_AW   = 3'd3,
        ST_W    = 3'd4,
        ST_B    = 3'd5
    } master_state_e;

endpackage

// ==== logic/cache_req_decode.sv ====
`timescale 1ns/1ps

module cache_req_decode (
    input  logic [1:0]                         caddr_i,
    input  axi_pkg::wtype_e                    cwtype_i,
    input  logic [axi_pkg::DATA_BITS-1:0]      cdata_i,
    input  logic                               single_i,
    output logic [axi_pkg::STRB_BITS-1:0]      wstrb_o,
    output logic [axi_pkg::DATA_BITS-1:0]      wdata_o,
    output logic [axi_pkg::LEN_BITS-1:0]       rd_len_o
);

    // Strobe placed by the low address bits
    always_comb begin
        case (cwtype_i)
            axi_pkg::WT_BYTE: begin
                wstrb_o = 4'b0001 << caddr_i;
            end
            axi_pkg::WT_HALF: begin
                if (caddr_i[1]) begin
                    wstrb_o = 4'b1100;
                end else begin
                    wstrb_o = 4'b0011;
                end
            end
            default: begin
                wstrb_o = 4'b1111;
            end
        endcase
    end

    // Copy the low byte or halfword into every lane
    always_comb begin
        case (cwtype_i)
            axi_pkg::WT_BYTE: begin
                wdata_o = {4{cdata_i[7:0]}};
            end
            axi_pkg::WT_HALF: begin
                wdata_o = {2{cdata_i[15:0]}};
            end
            default: begin
                wdata_o = cdata_i;
            end
        endcase
    end

    // Single word or a full line
    always_comb begin
        if (single_i) begin
            rd_len_o = axi_pkg::LEN_ONE;
        end else begin
            rd_len_o = axi_pkg::LEN_FOUR;
        end
    end

endmodule

// ==== logic/axi_master.sv ====
`timescale 1ns/1ps

module axi_master (
    input  logic                               clk,
    input  logic                               rst,
    // Cache request
    input  logic                               creq_i,
    input  logic                               cwrite_i,
    input  logic [axi_pkg::DATA_BITS-1:0]      caddr_i,
    input  logic [axi_pkg::STRB_BITS-1:0]      wstrb_i,
    input  logic [axi_pkg::DATA_BITS-1:0]      wdata_i,
    input  logic [axi_pkg::LEN_BITS-1:0]       rd_len_i,
    // Slave responses
    input  logic                               arready_i,
    input  logic                               awready_i,
    input  logic                               wready_i,
    input  logic                               rvalid_i,
    input  logic [axi_pkg::DATA_BITS-1:0]      rdata_i,
    input  logic                               rlast_i,
    input  logic                               bvalid_i,
    // AR channel
    output logic                               arvalid_o,
    output logic [axi_pkg::DATA_BITS-1:0]      araddr_o,
    output logic [axi_pkg::LEN_BITS-1:0]       arlen_o,
    output logic [axi_pkg::BURST_BITS-1:0]     arburst_o,
    output logic [axi_pkg::SIZE_BITS-1:0]      arsize_o,
    // AW channel
    output logic                               awvalid_o,
    output logic [axi_pkg::DATA_BITS-1:0]      awaddr_o,
    output logic [axi_pkg::LEN_BITS-1:0]       awlen_o,
    output logic [axi_pkg::BURST_BITS-1:0]     awburst_o,
    output logic [axi_pkg::SIZE_BITS-1:0]      awsize_o,
    // W channel
    output logic                               wvalid_o,
    output logic [axi_pkg::DATA_BITS-1:0]      wdata_o,
    output logic [axi_pkg::STRB_BITS-1:0]      wstrb_o,
    output logic                               wlast_o,
    output logic                               rready_o,
    output logic                               bready_o,
    // Back to the cache
    output logic [axi_pkg::DATA_BITS-1:0]      rdata_o,
    output logic                               wait_o
);

    axi_pkg::master_state_e state_q;
    axi_pkg::master_state_e state_d;

    logic arhns;
    logic awhns;
    logic whns;
    logic rhns;
    logic bhns;
    logic rd_done;
    logic req_rd;
    logic req_wr;
    logic [axi_pkg::DATA_BITS-1:0] rdata_q;

    assign req_rd = creq_i & ~cwrite_i;
    assign req_wr = creq_i & cwrite_i;

    assign arhns   = arvalid_o & arready_i;
    assign awhns   = awvalid_o & awready_i;
    assign whns    = wvalid_o & wready_i;
    assign rhns    = rready_o & rvalid_i;
    assign bhns    = bready_o & bvalid_i;
    assign rd_done = rhns & rlast_i;

    // Request payload comes straight from the cache, held while waiting
    assign araddr_o  = caddr_i;
    assign arlen_o   = rd_len_i;
    assign arburst_o = axi_pkg::BURST_INCR;
    assign arsize_o  = axi_pkg::SIZE_WORD;
    assign awaddr_o  = caddr_i;
    assign awlen_o   = axi_pkg::LEN_ONE;
    assign awburst_o = axi_pkg::BURST_FIXED;
    assign awsize_o  = axi_pkg::SIZE_WORD;
    assign wdata_o   = wdata_i;
    assign wstrb_o   = wstrb_i;
    assign wlast_o   = 1'b1;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= axi_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            axi_pkg::ST_IDLE: begin
                if (req_rd) begin
                    state_d = arhns ? axi_pkg::ST_R : axi_pkg::ST_AR;
                end else if (req_wr) begin
                    state_d = awhns ? axi_pkg::ST_W : axi_pkg::ST_AW;
                end
            end
            axi_pkg::ST_AR: if (arhns) state_d = axi_pkg::ST_R;
            axi_pkg::ST_R:  if (rd_done) state_d = axi_pkg::ST_IDLE;
            axi_pkg::ST_AW: if (awhns) state_d = axi_pkg::ST_W;
            axi_pkg::ST_W:  if (whns) state_d = axi_pkg::ST_B;
            axi_pkg::ST_B:  if (bhns) state_d = axi_pkg::ST_IDLE;
            default: state_d = axi_pkg::ST_IDLE;
        endcase
    end

    // Valids and readies per state
    always_comb begin
        arvalid_o = 1'b0;
        awvalid_o = 1'b0;
        wvalid_o  = 1'b0;
        rready_o  = 1'b0;
        bready_o  = 1'b0;
        case (state_q)
            axi_pkg::ST_IDLE: begin
                arvalid_o = req_rd;
                awvalid_o = req_wr;
            end
            axi_pkg::ST_AR: arvalid_o = 1'b1;
            axi_pkg::ST_R:  rready_o  = 1'b1;
            axi_pkg::ST_AW: awvalid_o = 1'b1;
            axi_pkg::ST_W:  wvalid_o  = 1'b1;
            axi_pkg::ST_B:  bready_o  = 1'b1;
            default: ;
        endcase
    end

    // Last beat kept for the cache between beats
    always_ff @(posedge clk) begin
        if (rhns) begin
            rdata_q <= rdata_i;
        end
    end

    assign rdata_o = rhns ? rdata_i : rdata_q;

    // A new request during the B phase waits for the response
    always_comb begin
        case (state_q)
            axi_pkg::ST_IDLE: wait_o = creq_i;
            axi_pkg::ST_AR:   wait_o = 1'b1;
            axi_pkg::ST_R:    wait_o = ~rhns;
            axi_pkg::ST_AW:   wait_o = 1'b1;
            axi_pkg::ST_W:    wait_o = ~whns;
            axi_pkg::ST_B:    wait_o = creq_i;
            default:          wait_o = creq_i;
        endcase
    end

endmodule

// ==== logic/axi_sram_slave.sv ====
`timescale 1ns/1ps

module axi_sram_slave (
    input  logic                               clk,
    input  logic                               rst,
    // AR channel
    input  logic                               arvalid_i,
    input  logic [axi_pkg::DATA_BITS-1:0]      araddr_i,
    input  logic [axi_pkg::LEN_BITS-1:0]       arlen_i,
    input  logic [axi_pkg::BURST_BITS-1:0]     arburst_i,
    // AW channel
    input  logic                               awvalid_i,
    input  logic [axi_pkg::DATA_BITS-1:0]      awaddr_i,
    input  logic [axi_pkg::BURST_BITS-1:0]     awburst_i,
    // W channel
    input  logic                               wvalid_i,
    input  logic [axi_pkg::DATA_BITS-1:0]      wdata_i,
    input  logic [axi_pkg::STRB_BITS-1:0]      wstrb_i,
    input  logic                               rready_i,
    input  logic                               bready_i,
    output logic                               arready_o,
    output logic                               awready_o,
    output logic                               wready_o,
    output logic                               rvalid_o,
    output logic [axi_pkg::DATA_BITS-1:0]      rdata_o,
    output logic                               rlast_o,
    output logic                               bvalid_o
);

    logic [axi_pkg::DATA_BITS-1:0] mem [axi_pkg::MEM_WORDS];

    logic [axi_pkg::DATA_BITS-1:0]  addr_q;
    logic [axi_pkg::DATA_BITS-1:0]  addr_next;
    logic [axi_pkg::BURST_BITS-1:0] burst_q;
    logic [axi_pkg::LEN_BITS-1:0]   beats_left_q;
    logic busy;
    logic last_beat;
    logic arhns;
    logic awhns;
    logic whns;
    logic rhns;
    logic bhns;

    // Accepts one address at a time, reads first if both arrive
    assign busy      = rvalid_o | wready_o | bvalid_o;
    assign arready_o = ~busy;
    assign awready_o = ~busy & ~arvalid_i;

    assign arhns = arvalid_i & arready_o;
    assign awhns = awvalid_i & awready_o;
    assign whns  = wvalid_i & wready_o;
    assign rhns  = rvalid_o & rready_i;
    assign bhns  = bvalid_o & bready_i;

    assign last_beat = (beats_left_q == '0);
    assign rlast_o   = rvalid_o & last_beat;

    always_comb begin
        if (burst_q == axi_pkg::BURST_INCR) begin
            addr_next = addr_q + axi_pkg::DATA_BITS'(axi_pkg::STRB_BITS);
        end else begin
            addr_next = addr_q;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rvalid_o     <= 1'b0;
            wready_o     <= 1'b0;
            bvalid_o     <= 1'b0;
            beats_left_q <= '0;
        end else begin
            if (arhns) begin
                rvalid_o     <= 1'b1;
                beats_left_q <= arlen_i;
            end else if (rhns) begin
                if (last_beat) begin
                    rvalid_o <= 1'b0;
                end else begin
                    beats_left_q <= beats_left_q - 1'b1;
                end
            end
            if (awhns) begin
                wready_o <= 1'b1;
            end else if (whns) begin
                wready_o <= 1'b0;
            end
            // B response one cycle after the data
            if (whns) begin
                bvalid_o <= 1'b1;
            end else if (bhns) begin
                bvalid_o <= 1'b0;
            end
        end
    end

    // Burst address and type
    always_ff @(posedge clk) begin
        if (arhns) begin
            addr_q  <= araddr_i;
            burst_q <= arburst_i;
        end else if (awhns) begin
            addr_q  <= awaddr_i;
            burst_q <= awburst_i;
        end else if (rhns || whns) begin
            addr_q <= addr_next;
        end
    end

    // Byte lanes written under the strobe
    always_ff @(posedge clk) begin
        if (whns) begin
            for (int i = 0; i < axi_pkg::STRB_BITS; i++) begin
                if (wstrb_i[i]) begin
                    mem[addr_q[9:2]][8*i +: 8] <= wdata_i[8*i +: 8];
                end
            end
        end
    end

    assign rdata_o = mem[addr_q[9:2]];

endmodule

// ==== logic/axi_cache_port.sv ====
`timescale 1ns/1ps

module axi_cache_port (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               creq_i,
    input  logic                               cwrite_i,
    input  logic                               single_i,
    input  axi_pkg::wtype_e                    cwtype_i,
    input  logic [axi_pkg::DATA_BITS-1:0]      caddr_i,
    input  logic [axi_pkg::DATA_BITS-1:0]      cdata_i,
    output logic [axi_pkg::DATA_BITS-1:0]      rdata_o,
    output logic                               wait_o
);

    // Decoded request
    logic [axi_pkg::STRB_BITS-1:0]  wstrb;
    logic [axi_pkg::DATA_BITS-1:0]  wdata_aligned;
    logic [axi_pkg::LEN_BITS-1:0]   rd_len;

    // AXI channels
    logic                           arvalid;
    logic                           arready;
    logic [axi_pkg::DATA_BITS-1:0]  araddr;
    logic [axi_pkg::LEN_BITS-1:0]   arlen;
    logic [axi_pkg::BURST_BITS-1:0] arburst;
    logic                           awvalid;
    logic                           awready;
    logic [axi_pkg::DATA_BITS-1:0]  awaddr;
    logic [axi_pkg::BURST_BITS-1:0] awburst;
    logic                           wvalid;
    logic                           wready;
    logic [axi_pkg::DATA_BITS-1:0]  axi_wdata;
    logic [axi_pkg::STRB_BITS-1:0]  axi_wstrb;
    logic                           rvalid;
    logic                           rready;
    logic [axi_pkg::DATA_BITS-1:0]  axi_rdata;
    logic                           rlast;
    logic                           bvalid;
    logic                           bready;

    cache_req_decode u_decode (
        .caddr_i  (caddr_i[1:0]),
        .cwtype_i (cwtype_i),
        .cdata_i  (cdata_i),
        .single_i (single_i),
        .wstrb_o  (wstrb),
        .wdata_o  (wdata_aligned),
        .rd_len_o (rd_len)
    );

    // Size, write length and wlast are fixed, the slave does not read them
    axi_master u_master (
        .clk       (clk),
        .rst       (rst),
        .creq_i    (creq_i),
        .cwrite_i  (cwrite_i),
        .caddr_i   (caddr_i),
        .wstrb_i   (wstrb),
        .wdata_i   (wdata_aligned),
        .rd_len_i  (rd_len),
        .arready_i (arready),
        .awready_i (awready),
        .wready_i  (wready),
        .rvalid_i  (rvalid),
        .rdata_i   (axi_rdata),
        .rlast_i   (rlast),
        .bvalid_i  (bvalid),
        .arvalid_o (arvalid),
        .araddr_o  (araddr),
        .arlen_o   (arlen),
        .arburst_o (arburst),
        .arsize_o  (),
        .awvalid_o (awvalid),
        .awaddr_o  (awaddr),
        .awlen_o   (),
        .awburst_o (awburst),
        .awsize_o  (),
        .wvalid_o  (wvalid),
        .wdata_o   (axi_wdata),
        .wstrb_o   (axi_wstrb),
        .wlast_o   (),
        .rready_o  (rready),
        .bready_o  (bready),
        .rdata_o   (rdata_o),
        .wait_o    (wait_o)
    );

    axi_sram_slave u_slave (
        .clk       (clk),
        .rst       (rst),
        .arvalid_i (arvalid),
        .araddr_i  (araddr),
        .arlen_i   (arlen),
        .arburst_i (arburst),
        .awvalid_i (awvalid),
        .awaddr_i  (awaddr),
        .awburst_i (awburst),
        .wvalid_i  (wvalid),
        .wdata_i   (axi_wdata),
        .wstrb_i   (axi_wstrb),
        .rready_i  (rready),
        .bready_i  (bready),
        .arready_o (arready),
        .awready_o (awready),
        .wready_o  (wready),
        .rvalid_o  (rvalid),
        .rdata_o   (axi_rdata),
        .rlast_o   (rlast),
        .bvalid_o  (bvalid)
    );

endmodule

// ==== sim/axi_cache_port_props.sv ====
`timescale 1ns/1ps

module axi_cache_port_props (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               arvalid_i,
    input  logic                               arready_i,
    input  logic [axi_pkg::DATA_BITS-1:0]      araddr_i,
    input  logic                               awvalid_i,
    input  logic                               awready_i,
    input  logic [axi_pkg::DATA_BITS-1:0]      awaddr_i,
    input  logic                               wvalid_i,
    input  logic [axi_pkg::STRB_BITS-1:0]      wstrb_i,
    input  logic                               rvalid_i,
    input  logic                               bvalid_i,
    input  logic                               rready_i,
    input  logic                               bready_i
);

    // Failed assertions so far
    int unsigned fail_count = 0;

    // Address held until accepted
    ar_hold: assert property (@(posedge clk) disable iff (!rst)
        arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i))
        else begin
            fail_count++;
            $error("arvalid dropped or araddr changed before arready");
        end

    aw_hold: assert property (@(posedge clk) disable iff (!rst)
        awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i))
        else begin
            fail_count++;
            $error("awvalid dropped or awaddr changed before awready");
        end

    // Everything quiet while in reset
    reset_quiet: assert property (@(posedge clk)
        !rst |-> !arvalid_i && !awvalid_i && !wvalid_i && !rvalid_i
                 && !bvalid_i && !rready_i && !bready_i)
        else begin
            fail_count++;
            $error("valid or ready high during reset");
        end

    w_strobe: assert property (@(posedge clk) disable iff (!rst)
        wvalid_i |-> wstrb_i != '0)
        else begin
            fail_count++;
            $error("write data sent with an empty strobe");
        end

    // One response channel at a time
    ready_excl: assert property (@(posedge clk) disable iff (!rst)
        !(rready_i && bready_i))
        else begin
            fail_count++;
            $error("rready and bready high together");
        end

endmodule

bind axi_master axi_cache_port_props u_props (
    .clk       (clk),
    .rst       (rst),
    .arvalid_i (arvalid_o),
    .arready_i (arready_i),
    .araddr_i  (araddr_o),
    .awvalid_i (awvalid_o),
    .awready_i (awready_i),
    .awaddr_i  (awaddr_o),
    .wvalid_i  (wvalid_o),
    .wstrb_i   (wstrb_o),
    .rvalid_i  (rvalid_i),
    .bvalid_i  (bvalid_i),
    .rready_i  (rready_o),
    .bready_i  (bready_o)
);

// ==== sim/tb_axi_cache_port.sv ====
`timescale 1ns/1ps

module tb_axi_cache_port;

    localparam int          RST_CYCLES  = 8;
    localparam int          WAIT_LIMIT  = 50;
    localparam int          IDLE_CYCLES = 10;
    localparam int          RANDOM_REQS = 200;
    localparam logic [31:0] LFSR_SEED   = 32'h6cc3_a3a4;
    localparam logic [31:0] LFSR_TAPS   = 32'hd000_0001;

    logic            clk;
    logic            rst;
    logic            creq;
    logic            cwrite;
    logic            single;
    axi_pkg::wtype_e cwtype;
    logic [31:0]     caddr;
    logic [31:0]     cdata;
    logic [31:0]     cache_rdata;
    logic            cache_wait;

    // Expected memory contents by word index
    logic [31:0] shadow [256];
    logic [31:0] lfsr_q;

    axi_cache_port dut_i (
        .clk      (clk),
        .rst      (rst),
        .creq_i   (creq),
        .cwrite_i (cwrite),
        .single_i (single),
        .cwtype_i (cwtype),
        .caddr_i  (caddr),
        .cdata_i  (cdata),
        .rdata_o  (cache_rdata),
        .wait_o   (cache_wait)
    );

    always #2 clk = ~clk;

    // Stop at the first failed bound assertion
    always @(negedge clk) begin
        if (dut_i.u_master.u_props.fail_count != 0) begin
            $display("FAIL: see errors above");
            $fatal(1, "bound assertion failed");
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int b = 0; b < n; b++) begin
            val = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    function automatic logic [31:0] fill_word(input logic [7:0] idx);
        return {idx, ~idx, idx ^ 8'h5a, idx + 8'h3c};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            $display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, got);
            $display("FAIL: see errors above");
            $fatal(1, "value mismatch");
        end
    endtask

    // Next cycle with wait_o low, sampled mid-cycle
    task automatic wait_served(output logic [31:0] data);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (cache_wait) begin
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                $display("Request at address %h was not served in %0d cycles", caddr, cycles);
                $display("FAIL: see errors above");
                $fatal(1, "timeout");
            end
            @(negedge clk);
        end
        data = cache_rdata;
    endtask

    task automatic shadow_write(input logic [31:0] addr, input axi_pkg::wtype_e wt,
                                input logic [31:0] data);
        logic [7:0] idx;
        int         lane;
        idx  = addr[9:2];
        lane = int'(addr[1:0]);
        case (wt)
            axi_pkg::WT_BYTE: shadow[idx][8*lane +: 8] = data[7:0];
            axi_pkg::WT_HALF: shadow[idx][16*(lane/2) +: 16] = data[15:0];
            default:          shadow[idx] = data;
        endcase
    endtask

    task automatic write_and_track(input logic [31:0] addr, input axi_pkg::wtype_e wt,
                                   input logic [31:0] data);
        logic [31:0] unused;
        @(posedge clk);
        creq   <= 1'b1;
        cwrite <= 1'b1;
        cwtype <= wt;
        caddr  <= addr;
        cdata  <= data;
        wait_served(unused);
        @(posedge clk);
        creq <= 1'b0;
        shadow_write(addr, wt, data);
    endtask

    task automatic read_and_compare(input logic [31:0] addr, input logic one_beat);
        logic [31:0] got;
        logic [7:0]  idx;
        int          beats;
        beats = one_beat ? 1 : 4;
        @(posedge clk);
        creq   <= 1'b1;
        cwrite <= 1'b0;
        single <= one_beat;
        caddr  <= addr;
        for (int k = 0; k < beats; k++) begin
            wait_served(got);
            idx = addr[9:2] + 8'(k);
            check_value("rdata_o", shadow[idx], got);
        end
        @(posedge clk);
        creq <= 1'b0;
    endtask

    task automatic random_request();
        logic [31:0]     kind;
        logic [31:0]     addr;
        logic [31:0]     wt_bits;
        logic [31:0]     data;
        axi_pkg::wtype_e wt;
        take_bits(2, kind);
        take_bits(10, addr);
        take_bits(2, wt_bits);
        take_bits(32, data);
        case (wt_bits[1:0])
            2'd0:    wt = axi_pkg::WT_BYTE;
            2'd1:    wt = axi_pkg::WT_HALF;
            default: wt = axi_pkg::WT_WORD;
        endcase
        case (kind[1:0])
            2'd0, 2'd1: write_and_track(addr, wt, data);
            2'd2:       read_and_compare({addr[31:2], 2'b00}, 1'b1);
            default:    read_and_compare({addr[31:4], 4'h0}, 1'b0);
        endcase
    endtask

    initial begin
        clk    = 1'b0;
        rst    = 1'b0;
        creq   = 1'b0;
        cwrite = 1'b0;
        single = 1'b1;
        cwtype = axi_pkg::WT_WORD;
        caddr  = '0;
        cdata  = '0;
        lfsr_q = LFSR_SEED;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b1;

        // Nothing waits without a request
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_value("wait_o", 32'd0, {31'd0, cache_wait});
        end

        for (int i = 0; i < 256; i++) begin
            write_and_track(32'(i) << 2, axi_pkg::WT_WORD, fill_word(8'(i)));
        end

        write_and_track(32'h0000_0124, axi_pkg::WT_WORD, 32'hdead_beef);
        read_and_compare(32'h0000_0124, 1'b1);

        // Sub-word writes at every offset
        for (int off = 0; off < 4; off++) begin
            write_and_track(32'h0000_0200 + 32'(off), axi_pkg::WT_BYTE,
                            32'h1234_56a0 + 32'(off));
            read_and_compare(32'h0000_0200, 1'b1);
        end
        for (int off = 0; off < 4; off++) begin
            write_and_track(32'h0000_0210 + 32'(off), axi_pkg::WT_HALF,
                            32'hfeed_c0d0 + 32'(off));
            read_and_compare(32'h0000_0210, 1'b1);
        end

        // Line fills ending at word 19 and at the last memory word
        read_and_compare(32'h0000_0040, 1'b0);
        read_and_compare(32'h0000_03f0, 1'b0);

        repeat (RANDOM_REQS) begin
            random_request();
        end

        @(negedge clk);
        if (dut_i.u_master.u_props.fail_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("FAIL: see errors above");
            $fatal(1, "bound assertion failed");
        end
    end

endmodule

// ==== axi_cache_port.f ====
logic/axi_pkg.sv
logic/cache_req_decode.sv
logic/axi_master.sv
logic/axi_sram_slave.sv
logic/axi_cache_port.sv
sim/axi_cache_port_props.sv
sim/tb_axi_cache_port.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator; the exit status is the result
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_axi_cache_port \
    -f axi_cache_port.f

./obj_dir/Vtb_axi_cache_port
